// ==== dv/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
	input  logic                      cclk,
	input  logic                      cclk_rst_b,
	input  uart_types_pkg::sys_byte_t sys_odata,
	input  logic                      tx_full,
	input  logic                      serial_tx,
	input  logic                      serial_rx,
	input  uart_types_pkg::sys_byte_t sys_idata,
	input  logic                      rx_frame_err,
	input  int                        test_num,
	input  logic                      test_done,
	output logic                      quiet,
	output logic                      model_full,
	output int                        tests_passed,
	output int                        tests_failed,
	output int                        err_total
);

	import uart_cfg_pkg::*;

	localparam int TX = 0;
	localparam int RX = 1;
	localparam int EV_NONE = 0;
	localparam int EV_START = 1;
	localparam int EV_GOOD = 2;
	localparam int EV_BAD = 3;
	localparam int EV_GLITCH = 4;
	localparam int EV_SKEW = 5;

	logic line_prev [2];
	logic line_busy [2];
	int line_t [2]; // Cycles since the start edge, one at the first sample.
	logic [7:0] line_shift [2];
	logic [7:0] tx_exp_q [$]; // Bytes the FIFO holds, so its size is the occupancy.
	int tx_wr_q [$];
	logic [7:0] rx_exp_q [$];
	int rx_due_q [$];
	int err_due_q [$];
	logic [7:0] tx_cur;
	int cyc = 0;
	int prev_end = 0; // Cycle at which the last transmitted frame ends.
	int test_errs = 0;
	int n_pass = 0;
	int n_fail = 0;
	int n_err = 0;

	assign tests_passed = n_pass;
	assign tests_failed = n_fail;
	assign err_total = n_err;

	task automatic report_error(input string msg);
		$display("error %0t ns: %s", $time, msg);
		test_errs = test_errs + 1;
		n_err = n_err + 1;
	endtask

	function automatic string test_name(input int n);
		case (n)
			1: return "reset state";
			2: return "spaced transmit";
			3: return "burst and overflow";
			4: return "receive";
			5: return "framing error";
			default: return "loopback";
		endcase
	endfunction

	// 8N1 decoder, sampling each bit in its middle.
	function automatic int decode_step(input int ln, input logic line);
		int ev;
		int k;
		ev = EV_NONE;
		if (!line_busy[ln]) begin
			if (line_prev[ln] && !line) begin
				line_busy[ln] = 1'b1;
				line_t[ln] = 1;
				ev = EV_START;
			end
		end else begin
			line_t[ln] = line_t[ln] + 1;
			if (line != line_prev[ln] && (line_t[ln] - 1) % BIT_CYCLES != 0) begin
				ev = EV_SKEW; // Edges may only fall on the bit grid.
			end
			if ((line_t[ln] - 1) % BIT_CYCLES == BIT_CYCLES / 2) begin
				k = (line_t[ln] - 1) / BIT_CYCLES;
				if (k == 0 && line) begin
					line_busy[ln] = 1'b0;
					ev = EV_GLITCH;
				end else if (k >= 1 && k <= DATA_BITS) begin
					line_shift[ln] = {line, line_shift[ln][7:1]};
				end else if (k == DATA_BITS + 1) begin
					line_busy[ln] = 1'b0;
					ev = line ? EV_GOOD : EV_BAD;
				end
			end
		end
		line_prev[ln] = line;
		return ev;
	endfunction

	always @(posedge cclk) begin : watch
		int ev;
		int first;
		logic [7:0] want;
		cyc = cyc + 1;
		if (!cclk_rst_b) begin
			if (cyc > 1 && (!serial_tx || tx_full || sys_idata.valid || rx_frame_err)) begin
				report_error("outputs away from their reset values during reset");
			end
			for (int i = 0; i < 2; i++) begin
				line_prev[i] = 1'b1;
				line_busy[i] = 1'b0;
			end
			tx_exp_q.delete();
			tx_wr_q.delete();
			rx_exp_q.delete();
			rx_due_q.delete();
			err_due_q.delete();
			prev_end = 0;
		end else begin
			ev = decode_step(TX, serial_tx);
			case (ev)
				EV_START: begin
					if (tx_exp_q.size() == 0) begin
						report_error("start bit on serial_tx with no byte queued");
					end else begin
						tx_cur = tx_exp_q.pop_front();
						first = tx_wr_q.pop_front() + 1; // Earliest wrap after the write.
						if (prev_end > first) begin
							first = prev_end;
						end
						if (cyc - 1 < first || cyc - 1 >= first + BIT_CYCLES) begin
							report_error($sformatf("start bit at cycle %0d, window %0d to %0d",
								cyc - 1, first, first + BIT_CYCLES - 1));
						end
					end
					prev_end = cyc - 1 + 10 * BIT_CYCLES;
				end
				EV_GOOD: begin
					if (line_shift[TX] != tx_cur) begin
						report_error($sformatf("serial_tx sent %02h, expected %02h",
							line_shift[TX], tx_cur));
					end
				end
				EV_BAD: report_error("stop bit low on serial_tx");
				EV_GLITCH: report_error("start bit on serial_tx ended early");
				EV_SKEW: report_error("bit edge on serial_tx off the bit grid");
				default: ;
			endcase
			if (tx_full != (tx_exp_q.size() == FIFO_DEPTH)) begin
				report_error($sformatf("tx_full is %0b with %0d bytes queued",
					tx_full, tx_exp_q.size()));
			end
			if (sys_odata.valid && tx_exp_q.size() < FIFO_DEPTH) begin
				tx_exp_q.push_back(sys_odata.data);
				tx_wr_q.push_back(cyc);
			end

			ev = decode_step(RX, serial_rx);
			first = cyc - line_t[RX] + 11 * BIT_CYCLES + 1; // One bit past the frame end.
			if (ev == EV_GOOD) begin
				rx_exp_q.push_back(line_shift[RX]);
				rx_due_q.push_back(first);
			end else if (ev == EV_BAD) begin
				err_due_q.push_back(first);
			end else if (ev == EV_GLITCH || ev == EV_SKEW) begin
				report_error("malformed frame on serial_rx");
			end
			if (sys_idata.valid) begin
				if (rx_exp_q.size() == 0) begin
					report_error($sformatf("unexpected byte %02h on sys_idata", sys_idata.data));
				end else begin
					want = rx_exp_q.pop_front();
					first = rx_due_q.pop_front();
					if (sys_idata.data != want) begin
						report_error($sformatf("sys_idata is %02h, expected %02h",
							sys_idata.data, want));
					end
				end
			end
			if (rx_frame_err) begin
				if (err_due_q.size() == 0) begin
					report_error("unexpected rx_frame_err strobe");
				end else begin
					first = err_due_q.pop_front();
				end
			end
			if (rx_due_q.size() != 0 && cyc > rx_due_q[0]) begin
				report_error($sformatf("no sys_idata strobe for byte %02h", rx_exp_q[0]));
				want = rx_exp_q.pop_front();
				first = rx_due_q.pop_front();
			end
			if (err_due_q.size() != 0 && cyc > err_due_q[0]) begin
				report_error("no rx_frame_err strobe for a frame with a low stop bit");
				first = err_due_q.pop_front();
			end
		end
		if (test_done) begin
			if (test_errs == 0) begin
				n_pass = n_pass + 1;
				$display("test %0d %s: passed", test_num, test_name(test_num));
			end else begin
				n_fail = n_fail + 1;
				$display("test %0d %s: failed with %0d errors", test_num,
					test_name(test_num), test_errs);
			end
			test_errs = 0;
		end
		quiet = !line_busy[TX] && !line_busy[RX] && tx_exp_q.size() == 0 &&
			rx_exp_q.size() == 0 && err_due_q.size() == 0;
		model_full = (tx_exp_q.size() == FIFO_DEPTH);
	end

endmodule

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

	import uart_cfg_pkg::*;
	import uart_types_pkg::*;

	localparam int SPACED_BYTES = 12;
	localparam int BURST_BYTES = 30;
	localparam int RX_BYTES = 12;
	localparam int ERR_BYTES = 2;
	localparam int LOOP_BYTES = 20;
	localparam int TOTAL_BYTES = SPACED_BYTES + BURST_BYTES + RX_BYTES + ERR_BYTES + LOOP_BYTES;
	localparam int CYCLE_LIMIT = 2 * (TOTAL_BYTES * 10 * BIT_CYCLES) + 1000;

	logic cclk;
	logic cclk_rst_b;
	sys_byte_t sys_odata;
	sys_byte_t sys_idata;
	logic tx_full;
	logic serial_tx;
	logic serial_rx;
	logic rx_frame_err;
	logic rx_drive;
	logic loopback;
	int test_num;
	logic test_done;
	logic quiet;
	logic model_full;
	int tests_passed;
	int tests_failed;
	int err_total;
	int cycles = 0;
	logic [31:0] lfsr;

	initial cclk = 1'b0;
	always #10 cclk = ~cclk;

	assign serial_rx = loopback ? serial_tx : rx_drive;

	rs232_uart u_rs232_uart (
		.cclk(cclk),
		.cclk_rst_b(cclk_rst_b),
		.sys_odata(sys_odata),
		.tx_full(tx_full),
		.serial_tx(serial_tx),
		.serial_rx(serial_rx),
		.sys_idata(sys_idata),
		.rx_frame_err(rx_frame_err)
	);

	tb_checker u_checker (
		.cclk(cclk),
		.cclk_rst_b(cclk_rst_b),
		.sys_odata(sys_odata),
		.tx_full(tx_full),
		.serial_tx(serial_tx),
		.serial_rx(serial_rx),
		.sys_idata(sys_idata),
		.rx_frame_err(rx_frame_err),
		.test_num(test_num),
		.test_done(test_done),
		.quiet(quiet),
		.model_full(model_full),
		.tests_passed(tests_passed),
		.tests_failed(tests_failed),
		.err_total(err_total)
	);

	// Galois LFSR, one step per bit taken.
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic step();
		@(posedge cclk);
		#1;
	endtask

	task automatic idle(input int n);
		repeat (n) step();
	endtask

	task automatic drive_write(input logic [7:0] b);
		sys_odata = '{valid: 1'b1, data: b};
		step();
		sys_odata.valid = 1'b0;
	endtask

	task automatic send_frame(input logic [7:0] b, input logic stop);
		rx_drive = 1'b0;
		idle(BIT_CYCLES);
		for (int i = 0; i < DATA_BITS; i++) begin
			rx_drive = b[i]; // LSB first.
			idle(BIT_CYCLES);
		end
		rx_drive = stop;
		idle(BIT_CYCLES);
		rx_drive = 1'b1;
	endtask

	// Two steps let the checker see the last driven input first.
	task automatic wait_quiet();
		step();
		step();
		while (!quiet) begin
			step();
		end
	endtask

	task automatic finish_test(input int n);
		test_num = n;
		test_done = 1'b1;
		step();
		test_done = 1'b0;
	endtask

	initial begin
		lfsr = 32'd83482;
		cclk_rst_b = 1'b0;
		sys_odata = '0;
		rx_drive = 1'b1;
		loopback = 1'b0;
		test_num = 0;
		test_done = 1'b0;
		repeat (2) @(posedge cclk);
		#1 cclk_rst_b = 1'b1;

		idle(40);
		wait_quiet();
		finish_test(1);

		for (int i = 0; i < SPACED_BYTES; i++) begin
			drive_write(8'(take_bits(8)));
			wait_quiet();
			idle(BIT_CYCLES / 2 + int'(take_bits(4))); // Past the stop bit, random phase.
		end
		finish_test(2);

		for (int i = 0; i < BURST_BYTES; i++) begin
			drive_write(8'(take_bits(8)));
		end
		wait_quiet();
		finish_test(3);

		for (int i = 0; i < RX_BYTES; i++) begin
			send_frame(8'(take_bits(8)), 1'b1);
			idle(int'(take_bits(5)));
		end
		wait_quiet();
		finish_test(4);

		send_frame(8'(take_bits(8)), 1'b0);
		idle(2 * BIT_CYCLES);
		send_frame(8'(take_bits(8)), 1'b1);
		wait_quiet();
		finish_test(5);

		loopback = 1'b1;
		for (int i = 0; i < LOOP_BYTES; i++) begin
			while (model_full) begin
				step();
			end
			drive_write(8'(take_bits(8)));
			idle(int'(take_bits(5)));
		end
		wait_quiet();
		loopback = 1'b0;
		finish_test(6);

		step();
		$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && err_total == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	always @(posedge cclk) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles before all tests finished", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the UART testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=tb_top_sim
LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator is not on the PATH"
	exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_top \
	-Mdir "$BUILD_DIR" -o "$SIM_BIN"; then
	echo "build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if grep -q "TEST FAILED" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
exit 0

// ==== sim.f ====
verilog/uart_cfg_pkg.sv
verilog/uart_types_pkg.sv
verilog/byte_fifo.sv
verilog/rs232_tx.sv
verilog/rs232_rx.sv
verilog/rs232_uart.sv
dv/tb_checker.sv
dv/tb_top.sv

// ==== verilog/byte_fifo.sv ====
`timescale 1ns/1ps

module byte_fifo #(
	parameter int DEPTH = uart_cfg_pkg::FIFO_DEPTH
) (
	input  logic                     cclk,
	input  logic                     cclk_rst_b,
	input  logic                     wr_en,
	input  logic [7:0]               wr_data,
	input  logic                     rd_en,
	output uart_types_pkg::fifo_rd_t rd,
	output logic                     full
);

	logic [7:0] mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH):0] count;
	logic [7:0] rd_data;
	logic empty;
	logic push;
	logic pop;

	assign full = (count == ($clog2(DEPTH) + 1)'(DEPTH));
	assign empty = (count == '0);
	assign push = wr_en && !full; // Writes into a full queue are lost.
	assign pop = rd_en && !empty;

	assign rd = '{empty: empty, data: rd_data};

	always_ff @(posedge cclk) begin
		if (push) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// Read data stays put until the next pop.
	always_ff @(posedge cclk) begin
		if (pop) begin
			rd_data <= mem[rd_ptr];
		end
	end

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1; // Wraps on its own for a power of two depth.
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// The serializer must only pop when a byte is waiting.
	a_no_read_empty: assert property (
		@(posedge cclk) disable iff (!cclk_rst_b)
		rd_en |-> !empty
	) else $error("byte_fifo: read while empty");

	a_count_bound: assert property (
		@(posedge cclk) disable iff (!cclk_rst_b)
		count <= DEPTH
	) else $error("byte_fifo: count above depth");

endmodule

// ==== verilog/rs232_rx.sv ====
`timescale 1ns/1ps

module rs232_rx (
	input  logic                      cclk,
	input  logic                      cclk_rst_b,
	input  logic                      serial_rx,
	output uart_types_pkg::sys_byte_t sys_idata,
	output logic                      frame_err
);

	import uart_cfg_pkg::*;

	logic rx_meta;
	logic rx_sync;
	logic rx_sync_d;
	logic rx_busy;
	logic [$clog2(BIT_CYCLES)-1:0] rx_timer;
	logic [$clog2(BIT_CYCLES)-1:0] rx_target;
	logic [$clog2(DATA_BITS + 2)-1:0] rx_bit; // 0 start check, 1 to DATA_BITS data, then stop.
	logic [DATA_BITS-1:0] rx_shift;
	logic [DATA_BITS-1:0] rx_data;
	logic rx_valid;
	logic start_edge;
	logic sample;
	logic stop_bit;

	assign start_edge = !rx_busy && rx_sync_d && !rx_sync;
	assign stop_bit = (rx_bit == $bits(rx_bit)'(DATA_BITS + 1));

	// First sample lands half a bit in, the rest one bit apart.
	assign rx_target = (rx_bit == '0) ? $bits(rx_timer)'(BIT_CYCLES / 2 - 1) :
	                                    $bits(rx_timer)'(BIT_CYCLES - 1);
	assign sample = rx_busy && (rx_timer == rx_target);

	assign sys_idata = '{valid: rx_valid, data: rx_data};

	// The line idles high, so the synchronizer resets to one.
	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_sync_d <= 1'b1;
		end else begin
			rx_meta <= serial_rx;
			rx_sync <= rx_meta;
			rx_sync_d <= rx_sync;
		end
	end

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			rx_busy <= 1'b0;
			rx_timer <= '0;
			rx_bit <= '0;
			rx_valid <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			frame_err <= 1'b0;
			if (start_edge) begin
				rx_busy <= 1'b1;
				rx_timer <= '0;
				rx_bit <= '0;
			end else if (sample) begin
				rx_timer <= '0;
				if (rx_bit == '0 && rx_sync) begin
					rx_busy <= 1'b0; // Start bit went high again, so it was a glitch.
				end else if (stop_bit) begin
					rx_busy <= 1'b0;
					rx_valid <= rx_sync;
					frame_err <= !rx_sync;
				end else begin
					rx_bit <= rx_bit + 1'b1;
				end
			end else if (rx_busy) begin
				rx_timer <= rx_timer + 1'b1;
			end
		end
	end

	always_ff @(posedge cclk) begin
		if (sample && rx_bit != '0 && !stop_bit) begin
			rx_shift <= {rx_sync, rx_shift[DATA_BITS-1:1]};
		end
		if (sample && stop_bit && rx_sync) begin
			rx_data <= rx_shift; // Held until the next good frame.
		end
	end

	a_strobe_excl: assert property (
		@(posedge cclk) disable iff (!cclk_rst_b)
		!(sys_idata.valid && frame_err)
	) else $error("rs232_rx: byte and framing error together");

endmodule

// ==== verilog/rs232_tx.sv ====
`timescale 1ns/1ps

module rs232_tx (
	input  logic                     cclk,
	input  logic                     cclk_rst_b,
	input  uart_types_pkg::fifo_rd_t rd,
	output logic                     rd_en,
	output logic                     serial_tx
);

	import uart_cfg_pkg::*;

	logic [$clog2(BIT_CYCLES)-1:0] bit_timer;
	logic [$clog2(DATA_BITS + 2)-1:0] tx_state; // 0 idle, 1 to DATA_BITS data, then stop.
	logic [$clog2(DATA_BITS)-1:0] bit_idx;
	logic wrap;
	logic idle;
	logic stop;

	assign wrap = (bit_timer == $bits(bit_timer)'(BIT_CYCLES - 1));
	assign idle = (tx_state == '0);
	assign stop = (tx_state == $bits(tx_state)'(DATA_BITS + 1));
	assign bit_idx = $bits(bit_idx)'(tx_state - 1'b1);

	// The pop lands on the same edge that starts the start bit.
	assign rd_en = wrap && idle && !rd.empty;

	// The bit timer never stops, so a start bit waits for the next wrap.
	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			bit_timer <= '0;
		end else if (wrap) begin
			bit_timer <= '0;
		end else begin
			bit_timer <= bit_timer + 1'b1;
		end
	end

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			serial_tx <= 1'b1;
			tx_state <= '0;
		end else if (wrap) begin
			if (idle) begin
				serial_tx <= rd.empty; // Low start bit only when a byte is queued.
				if (!rd.empty) begin
					tx_state <= $bits(tx_state)'(1);
				end
			end else if (stop) begin
				serial_tx <= 1'b1;
				tx_state <= '0;
			end else begin
				serial_tx <= rd.data[bit_idx]; // LSB goes out first.
				tx_state <= tx_state + 1'b1;
			end
		end
	end

	// Between frames the line rests at the stop level.
	a_idle_high: assert property (
		@(posedge cclk) disable iff (!cclk_rst_b)
		idle |-> serial_tx
	) else $error("rs232_tx: line low while idle");

	a_pop_on_wrap: assert property (
		@(posedge cclk) disable iff (!cclk_rst_b)
		rd_en |=> (bit_timer == '0) && !serial_tx
	) else $error("rs232_tx: pop not aligned to a start bit");

endmodule

// ==== verilog/rs232_uart.sv ====
`timescale 1ns/1ps

module rs232_uart (
	input  logic                      cclk,
	input  logic                      cclk_rst_b,
	input  uart_types_pkg::sys_byte_t sys_odata,
	output logic                      tx_full,
	output logic                      serial_tx,
	input  logic                      serial_rx,
	output uart_types_pkg::sys_byte_t sys_idata,
	output logic                      rx_frame_err
);

	import uart_cfg_pkg::*;
	import uart_types_pkg::*;

	fifo_rd_t tx_rd;
	logic tx_rd_en;

	// Depth is taken as a power of two so the pointers wrap cleanly.
	byte_fifo #(
		.DEPTH(1 << FIFO_AW)
	) u_tx_fifo (
		.cclk(cclk),
		.cclk_rst_b(cclk_rst_b),
		.wr_en(sys_odata.valid),
		.wr_data(sys_odata.data),
		.rd_en(tx_rd_en),
		.rd(tx_rd),
		.full(tx_full)
	);

	rs232_tx u_tx (
		.cclk(cclk),
		.cclk_rst_b(cclk_rst_b),
		.rd(tx_rd),
		.rd_en(tx_rd_en),
		.serial_tx(serial_tx)
	);

	rs232_rx u_rx (
		.cclk(cclk),
		.cclk_rst_b(cclk_rst_b),
		.serial_rx(serial_rx),
		.sys_idata(sys_idata),
		.frame_err(rx_frame_err)
	);

endmodule

// ==== verilog/uart_cfg_pkg.sv ====
package uart_cfg_pkg;

	// Line timing.
	// The clock is picked against the baud rate so that one bit spans
	// sixteen cycles, which keeps simulated frames short.
	localparam int CCLK_HZ = 921_600;
	localparam int BAUD_RATE = 57_600;
	localparam int BIT_CYCLES = CCLK_HZ / BAUD_RATE; // Cycles per serial bit.

	// Frame format is fixed 8N1.
	localparam int DATA_BITS = 8;

	// Transmit queue sizing.
	localparam int FIFO_DEPTH = 16; // Bytes held ahead of the serializer.
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);

endpackage

// ==== verilog/uart_types_pkg.sv ====
package uart_types_pkg;

	// Host byte word, used both as a write strobe and as a receive strobe.
	typedef struct packed {
		logic valid; // High for one cycle per byte.
		logic [uart_cfg_pkg::DATA_BITS-1:0] data;
	} sys_byte_t;

	// Read side of the transmit FIFO as seen by the serializer.
	typedef struct packed {
		logic empty; // Level, follows the FIFO count.
		logic [uart_cfg_pkg::DATA_BITS-1:0] data; // Byte taken by the last pop.
	} fifo_rd_t;

endpackage
